// ==== Makefile ====
# Verilator build and run for the orientation testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := orientation_math_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
# keep running past an assertion so the testbench reports it
SIM_ARGS  := +verilator+error+limit+100

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/orientation_math_chk.sv ====
`timescale 1ns/1ps

module orientation_math_chk (
	input logic                       clock,
	input logic                       rst_n,
	input logic                       enable,
	input logic                       take,
	input orientation_pkg::polar_pt_t r_theta_original,
	input orientation_pkg::polar_pt_t r_theta_final,
	input logic                       done
);
	import orientation_pkg::*;

	// accepted enable still owed a done
	logic pending;
	// failures so far, read by the testbench
	int   fail_count = 0;

	// a new take wins over the done of the same cycle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (take) begin
			pending <= 1'b1;
		end else if (done) begin
			pending <= 1'b0;
		end
	end

	a_done_pulse: assert property (@(posedge clock) disable iff (!rst_n) done |=> !done)
		else begin
			fail_count = fail_count + 1;
			$error("done held high for more than one cycle");
		end

	// every done pairs with one accepted enable
	a_done_owed: assert property (@(posedge clock) disable iff (!rst_n) done |-> pending)
		else begin
			fail_count = fail_count + 1;
			$error("done without an accepted enable");
		end

	a_theta_range: assert property (@(posedge clock) disable iff (!rst_n)
		enable |-> (r_theta_original.theta_idx < theta_w'(n_theta))
			&& (r_theta_final.theta_idx < theta_w'(n_theta)))
		else begin
			fail_count = fail_count + 1;
			$error("angle index 12 or above with enable high");
		end

	a_reset_quiet: assert property (@(posedge clock) !rst_n |-> !done)
		else begin
			fail_count = fail_count + 1;
			$error("done high during reset");
		end

endmodule

bind orientation_math orientation_math_chk u_orientation_math_chk (
	.clock            (clock),
	.rst_n            (rst_n),
	.enable           (enable),
	.take             (take),
	.r_theta_original (r_theta_original),
	.r_theta_final    (r_theta_final),
	.done             (done)
);

// ==== dv/orientation_math_tb.sv ====
`timescale 1ns/1ps

module orientation_math_tb;
	import orientation_pkg::*;

	logic                clock;
	logic                rst_n;
	logic                enable;
	polar_pt_t           r_theta_original;
	polar_pt_t           r_theta_final;
	logic                done;
	logic [orient_w-1:0] orientation;

	// lcg state, one step per draw
	logic [31:0]         lcg_state;
	// scratch points for the random and overlap runs
	polar_pt_t           pt_a;
	polar_pt_t           pt_b;

	orientation_math u_orientation_math (
		.clock            (clock),
		.rst_n            (rst_n),
		.enable           (enable),
		.r_theta_original (r_theta_original),
		.r_theta_final    (r_theta_final),
		.done             (done),
		.orientation      (orientation)
	);

	// 10 ns period
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// reporting and compares
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_orientation(
		input logic [orient_w-1:0] got,
		input logic [orient_w-1:0] exp,
		input string               what
	);
		if (got !== exp) begin
			fail_now($sformatf("Mismatch at time %0t: %s orientation %0d, expected %0d",
				$time, what, got, exp));
		end
	endtask

	task automatic check_done(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			fail_now($sformatf("Mismatch at time %0t: %s done %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// any checker assertion that fired ends the run here
	always @(negedge clock) begin
		if (u_orientation_math.u_orientation_math_chk.fail_count != 0) begin
			fail_now("an assertion in the bound checker failed");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus and model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper lcg bits only, the low ones repeat quickly
	function automatic polar_pt_t random_point();
		logic [31:0] r_theta;
		logic [31:0] r_rad;
		polar_pt_t   p;
		r_theta     = lcg_next();
		r_rad       = lcg_next();
		p.theta_idx = theta_w'(r_theta[31:16] % 16'd12);
		p.radius    = r_rad[31:24];
		return p;
	endfunction

	// heading of final minus original, straight from the sector rule
	function automatic logic [orient_w-1:0] model_code(input polar_pt_t o, input polar_pt_t f);
		longint dx;
		longint dy;
		longint ax;
		longint ay;
		int     s;
		int     code;
		logic   stop;
		dx = longint'(f.radius) * longint'(cos_tab[f.theta_idx])
			- longint'(o.radius) * longint'(cos_tab[o.theta_idx]);
		dy = longint'(f.radius) * longint'(sin_tab[f.theta_idx])
			- longint'(o.radius) * longint'(sin_tab[o.theta_idx]);
		ax = (dx < 0) ? -dx : dx;
		ay = (dy < 0) ? -dy : dy;
		// count edges crossed until the first miss
		s    = 0;
		stop = 1'b0;
		for (logic [sect_w-1:0] j = '0; j < sect_w'(n_bound); j++) begin
			if (!stop && (ay * longint'(bound_cos[j]) >= ax * longint'(bound_sin[j]))) begin
				s++;
			end else begin
				stop = 1'b1;
			end
		end
		if (dx >= 0 && dy >= 0) begin
			code = s;
		end else if (dx < 0 && dy >= 0) begin
			code = 12 - s;
		end else if (dx < 0) begin
			code = 12 + s;
		end else begin
			// 360 folds back to 0
			code = (24 - s) % 24;
		end
		return orient_w'(code);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// sequencing
	////////////////////////////////////////////////////////////////////////////

	// one-cycle enable strobe
	task automatic apply_pair(input polar_pt_t orig, input polar_pt_t fin);
		@(negedge clock);
		enable           = 1'b1;
		r_theta_original = orig;
		r_theta_final    = fin;
		@(negedge clock);
		enable = 1'b0;
	endtask

	task automatic wait_done(output logic [orient_w-1:0] code);
		int cycles;
		cycles = 0;
		while (done !== 1'b1 && cycles < 20) begin
			@(negedge clock);
			cycles++;
		end
		if (done !== 1'b1) begin
			fail_now("done never came within 20 cycles after enable");
		end else begin
			code = orientation;
		end
	endtask

	task automatic run_pair(input polar_pt_t o, input polar_pt_t f, input string what);
		logic [orient_w-1:0] got;
		apply_pair(o, f);
		wait_done(got);
		check_orientation(got, model_code(o, f), what);
	endtask

	// directed case with a known answer, model cross-checked too
	task automatic run_fixed(
		input logic [11:0]         o,
		input logic [11:0]         f,
		input logic [orient_w-1:0] exp,
		input string               what
	);
		logic [orient_w-1:0] got;
		check_orientation(model_code(polar_pt_t'(o), polar_pt_t'(f)), exp, {what, " model"});
		apply_pair(polar_pt_t'(o), polar_pt_t'(f));
		wait_done(got);
		check_orientation(got, exp, what);
	endtask

	// done must stay quiet, orientation optionally pinned to 0
	task automatic expect_quiet(input int cycles, input logic zero_out, input string what);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clock);
			check_done(done, 1'b0, what);
			if (zero_out) begin
				check_orientation(orientation, '0, what);
			end
		end
	endtask

	initial begin
		lcg_state        = 32'hf46ee0d3;
		rst_n            = 1'b0;
		enable           = 1'b0;
		r_theta_original = '0;
		r_theta_final    = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;

		// idle after reset
		expect_quiet(5, 1'b1, "after reset");

		// fixture cases
		run_fixed(12'h110, 12'h115, 5'd1, "fixture 110 to 115");
		run_fixed(12'h110, 12'h105, 5'd13, "fixture 110 to 105");
		run_pair(polar_pt_t'(12'h3a0), polar_pt_t'(12'h980), "fixture 3a0 to 980");
		run_pair(polar_pt_t'(12'h5ff), polar_pt_t'(12'h0ff), "fixture 5ff to 0ff");
		run_pair(polar_pt_t'(12'h840), polar_pt_t'(12'h240), "fixture 840 to 240");
		run_pair(polar_pt_t'(12'hb20), polar_pt_t'(12'h7c8), "fixture b20 to 7c8");

		// axis moves and the zero vector
		run_fixed(12'h00a, 12'h032, 5'd0, "plus x");
		run_fixed(12'h032, 12'h00a, 5'd12, "minus x");
		run_fixed(12'h60a, 12'h632, 5'd6, "plus y");
		run_fixed(12'h632, 12'h60a, 5'd18, "minus y");
		run_fixed(12'h37f, 12'h37f, 5'd6, "equal points");
		run_fixed(12'h200, 12'h900, 5'd6, "both radii zero");

		// random pairs over all valid angles
		for (int i = 0; i < 400; i++) begin
			pt_a = random_point();
			pt_b = random_point();
			run_pair(pt_a, pt_b, $sformatf("random pair %0d", i));
		end

		// stray enable while busy is dropped
		apply_pair(polar_pt_t'(12'h110), polar_pt_t'(12'h115));
		apply_pair(polar_pt_t'(12'h110), polar_pt_t'(12'h105));
		begin : overlap_block
			logic [orient_w-1:0] got;
			wait_done(got);
			check_orientation(got, 5'd1, "first pair of overlap");
		end
		expect_quiet(20, 1'b0, "after overlap");

		// reset in flight kills the result
		apply_pair(polar_pt_t'(12'h4c3), polar_pt_t'(12'ha17));
		@(negedge clock);
		rst_n = 1'b0;
		expect_quiet(3, 1'b1, "during reset");
		rst_n = 1'b1;
		expect_quiet(20, 1'b1, "after mid-run reset");
		run_pair(polar_pt_t'(12'h4c3), polar_pt_t'(12'ha17), "recovery");

		if (u_orientation_math.u_orientation_math_chk.fail_count != 0) begin
			fail_now("an assertion in the bound checker failed");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

// ==== logic/heading_quantizer.sv ====
`timescale 1ns/1ps

module heading_quantizer (
	input  logic                                 clock,
	input  logic                                 rst_n,
	input  logic                                 start,
	input  orientation_pkg::diff_vec_t           vec,
	output logic                                 ready,
	output logic [orientation_pkg::orient_w-1:0] code
);
	import orientation_pkg::*;

	// absolute values of the incoming vector
	logic [mag_w-1:0]  abs_dx;
	logic [mag_w-1:0]  abs_dy;
	// latched search operands
	logic [mag_w-1:0]  mag_x;
	logic [mag_w-1:0]  mag_y;
	logic              neg_x;
	logic              neg_y;
	// search control
	logic              busy;
	logic [sect_w-1:0] bnd_idx;
	// cross products for the current boundary
	logic [prod_w-1:0] lhs;
	logic [prod_w-1:0] rhs;
	logic              crossed;
	logic              last_bnd;
	// sector count once the search ends
	logic [sect_w-1:0] sector;

	// fold sector and quadrant into the 0..23 code
	function automatic logic [orient_w-1:0] sector_code(
		input logic [sect_w-1:0] s,
		input logic              nx,
		input logic              ny
	);
		logic [orient_w-1:0] s_ext;
		logic [orient_w-1:0] result;
		s_ext = orient_w'(s);
		case ({nx, ny})
			// Q0 counts up from the x axis
			2'b00: result = s_ext;
			// Q1 counts down from 180
			2'b10: result = orient_w'(half_orient) - s_ext;
			// Q2 counts up from 180
			2'b11: result = orient_w'(half_orient) + s_ext;
			// Q3 counts down from 360, which wraps to 0
			default: result = (s_ext == '0) ? '0 : orient_w'(n_orient) - s_ext;
		endcase
		return result;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// operand capture
	////////////////////////////////////////////////////////////////////////////

	// max |diff| is 130560, fits in mag_w
	assign abs_dx = vec.dx[diff_w-1] ? mag_w'(-vec.dx) : mag_w'(vec.dx);
	assign abs_dy = vec.dy[diff_w-1] ? mag_w'(-vec.dy) : mag_w'(vec.dy);

	always_ff @(posedge clock) begin
		if (start) begin
			mag_x <= abs_dx;
			mag_y <= abs_dy;
			// zero counts as non-negative
			neg_x <= vec.dx[diff_w-1];
			neg_y <= vec.dy[diff_w-1];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// boundary test
	////////////////////////////////////////////////////////////////////////////

	// angle above edge j when |dy| cos >= |dx| sin
	assign lhs = mag_y * bound_cos[bnd_idx];
	assign rhs = mag_x * bound_sin[bnd_idx];
	assign crossed = lhs >= rhs;
	assign last_bnd = bnd_idx == sect_w'(n_bound - 1);

	// past the last edge means sector 6
	assign sector = crossed ? sect_w'(n_bound) : bnd_idx;

	////////////////////////////////////////////////////////////////////////////
	// search sequencing
	////////////////////////////////////////////////////////////////////////////

	// one edge per clock, stop at first miss
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			bnd_idx <= '0;
			ready   <= 1'b0;
			code    <= '0;
		end else begin
			ready <= 1'b0;
			if (start) begin
				busy    <= 1'b1;
				bnd_idx <= '0;
			end else if (busy) begin
				if (crossed && !last_bnd) begin
					bnd_idx <= bnd_idx + 1'b1;
				end else begin
					// latency 1..6 from the latch edge
					busy  <= 1'b0;
					ready <= 1'b1;
					code  <= sector_code(sector, neg_x, neg_y);
				end
			end
		end
	end

endmodule

// ==== logic/orientation_math.sv ====
`timescale 1ns/1ps

module orientation_math (
	input  logic                                 clock,
	input  logic                                 rst_n,
	input  logic                                 enable,
	input  orientation_pkg::polar_pt_t           r_theta_original,
	input  orientation_pkg::polar_pt_t           r_theta_final,
	output logic                                 done,
	output logic [orientation_pkg::orient_w-1:0] orientation
);
	import orientation_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_convert,
		st_diff,
		st_search
	} state_t;

	state_t              state;
	// enable seen while idle
	logic                take;
	// captured points
	polar_pt_t           orig_q;
	polar_pt_t           final_q;
	// converted points one clock behind the capture
	cart_pt_t            xy_orig;
	cart_pt_t            xy_final;
	// difference vector and quantizer handshake
	diff_vec_t           diff_q;
	logic                start_q;
	logic                q_ready;
	logic [orient_w-1:0] q_code;

	// busy block drops a stray enable
	assign take = (state == st_idle) && enable;

	////////////////////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (take) begin
			orig_q  <= r_theta_original;
			final_q <= r_theta_final;
		end
		// final minus original sign extended by one bit
		if (state == st_diff) begin
			diff_q.dx <= {xy_final.x[coord_w-1], xy_final.x}
				- {xy_orig.x[coord_w-1], xy_orig.x};
			diff_q.dy <= {xy_final.y[coord_w-1], xy_final.y}
				- {xy_orig.y[coord_w-1], xy_orig.y};
		end
	end

	polar_to_cart u_cart_orig (
		.clock (clock),
		.rst_n (rst_n),
		.pt    (orig_q),
		.xy    (xy_orig)
	);

	polar_to_cart u_cart_final (
		.clock (clock),
		.rst_n (rst_n),
		.pt    (final_q),
		.xy    (xy_final)
	);

	heading_quantizer u_heading_quantizer (
		.clock (clock),
		.rst_n (rst_n),
		.start (start_q),
		.vec   (diff_q),
		.ready (q_ready),
		.code  (q_code)
	);

	////////////////////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////////////////////

	// capture at 0, cartesian at 1, diff and start at 2, done at 5..10
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state       <= st_idle;
			start_q     <= 1'b0;
			done        <= 1'b0;
			orientation <= '0;
		end else begin
			start_q <= 1'b0;
			done    <= 1'b0;
			case (state)
				st_idle: begin
					if (take) begin
						state <= st_convert;
					end
				end
				// table multiply in flight
				st_convert: state <= st_diff;
				st_diff: begin
					state   <= st_search;
					start_q <= 1'b1;
				end
				st_search: begin
					// result held until the next done
					if (q_ready) begin
						orientation <= q_code;
						done        <= 1'b1;
						state       <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== logic/orientation_pkg.sv ====
package orientation_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and counts
	////////////////////////////////////////////////////////////////////////////

	// polar input word, angle index on top
	localparam int theta_w  = 4;
	localparam int radius_w = 8;

	// signed cartesian coordinate, 255 * 256 plus sign
	localparam int coord_w  = 18;
	// one extra bit for final minus original
	localparam int diff_w   = 19;

	// orientation code 0..23
	localparam int orient_w = 5;

	localparam int n_theta  = 12;
	localparam int n_bound  = 6;
	localparam int n_orient = 24;
	// code offset of the negative x axis
	localparam int half_orient = n_orient / 2;

	// table entry widths
	localparam int tab_w = 10;
	localparam int bnd_w = 9;

	// magnitude of a difference, sign dropped
	localparam int mag_w  = diff_w - 1;
	// cross product of a magnitude and a boundary entry
	localparam int prod_w = mag_w + bnd_w;
	// sector count 0..6 and boundary index 0..5
	localparam int sect_w = 3;

	////////////////////////////////////////////////////////////////////////////
	// trig tables, scaled by 256
	////////////////////////////////////////////////////////////////////////////

	// cos and sin of 15k degrees, k = 0..11
	localparam logic signed [tab_w-1:0] cos_tab [n_theta] = '{
		10'sd256, 10'sd247, 10'sd222, 10'sd181, 10'sd128, 10'sd66,
		10'sd0, -10'sd66, -10'sd128, -10'sd181, -10'sd222, -10'sd247
	};
	localparam logic signed [tab_w-1:0] sin_tab [n_theta] = '{
		10'sd0, 10'sd66, 10'sd128, 10'sd181, 10'sd222, 10'sd247,
		10'sd256, 10'sd247, 10'sd222, 10'sd181, 10'sd128, 10'sd66
	};

	// sector edges at 7.5 + 15j degrees, first quadrant only
	localparam logic [bnd_w-1:0] bound_cos [n_bound] = '{
		9'd254, 9'd237, 9'd203, 9'd156, 9'd98, 9'd33
	};
	localparam logic [bnd_w-1:0] bound_sin [n_bound] = '{
		9'd33, 9'd98, 9'd156, 9'd203, 9'd237, 9'd254
	};

	////////////////////////////////////////////////////////////////////////////
	// point types
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [theta_w-1:0]  theta_idx;
		logic [radius_w-1:0] radius;
	} polar_pt_t;

	typedef struct packed {
		logic signed [coord_w-1:0] x;
		logic signed [coord_w-1:0] y;
	} cart_pt_t;

	typedef struct packed {
		logic signed [diff_w-1:0] dx;
		logic signed [diff_w-1:0] dy;
	} diff_vec_t;

endpackage

// ==== logic/polar_to_cart.sv ====
`timescale 1ns/1ps

module polar_to_cart (
	input  logic                       clock,
	input  logic                       rst_n,
	input  orientation_pkg::polar_pt_t pt,
	output orientation_pkg::cart_pt_t  xy
);
	import orientation_pkg::*;

	// index inside the 0..165 degree range
	logic                      idx_ok;
	// table values for this angle
	logic signed [tab_w-1:0]   cos_val;
	logic signed [tab_w-1:0]   sin_val;
	// radius as a positive signed operand
	logic signed [radius_w:0]  rad_s;
	// full products, 255 * 256 still fits
	logic signed [coord_w-1:0] prod_x;
	logic signed [coord_w-1:0] prod_y;

	////////////////////////////////////////////////////////////////////////////
	// table lookup
	////////////////////////////////////////////////////////////////////////////

	// indices 12..15 have no entry
	assign idx_ok = pt.theta_idx < theta_w'(n_theta);

	// invalid angle maps to the origin
	assign cos_val = idx_ok ? cos_tab[pt.theta_idx] : '0;
	assign sin_val = idx_ok ? sin_tab[pt.theta_idx] : '0;

	////////////////////////////////////////////////////////////////////////////
	// scale by radius
	////////////////////////////////////////////////////////////////////////////

	// zero extend so the multiply stays signed
	assign rad_s = $signed({1'b0, pt.radius});

	// no shift, coordinates keep the x256 scale
	assign prod_x = rad_s * cos_val;
	assign prod_y = rad_s * sin_val;

	// result lands one clock after pt
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			xy <= '0;
		end else begin
			xy.x <= prod_x;
			xy.y <= prod_y;
		end
	end

endmodule

// ==== src.f ====
logic/orientation_pkg.sv
logic/polar_to_cart.sv
logic/heading_quantizer.sv
logic/orientation_math.sv
dv/orientation_math_chk.sv
dv/orientation_math_tb.sv
